//--- rtl/dummy_pe.sv
`timescale 1ns/10ps
`default_nettype none

module dummy_pe #(
    parameter int DELAY_CYCLES = 10,
    parameter int PE_INDEX     = 0
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          flush,
    input  wire                          kl_valid,
    input  wire                          kl_type,
    input  wire pe_array_pkg::tag_t      kl_data,
    input  wire logic [3:0]              kl_pe,
    input  wire                          in_valid,
    input  wire pe_array_pkg::operand_t  in_a,
    input  wire pe_array_pkg::operand_t  in_b,
    output logic                         configured,
    output logic                         match,
    output logic                         out_valid,
    output pe_array_pkg::operand_t       out_a,
    output pe_array_pkg::operand_t       out_b
);

    // Admission gate
    logic                   admit;
    pe_array_pkg::operand_t gated_a;
    pe_array_pkg::operand_t gated_b;

    // Configuration side
    pe_tag_match #(
        .PE_INDEX(PE_INDEX)
    ) u_tag_match (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .kl_valid  (kl_valid),
        .kl_type   (kl_type),
        .kl_data   (kl_data),
        .kl_pe     (kl_pe),
        .configured(configured),
        .match     (match)
    );

    // Bubble when not selected, zero data keeps idle stages quiet
    assign admit   = in_valid && match;
    assign gated_a = admit ? in_a : '0;
    assign gated_b = admit ? in_b : '0;

    // Calculation side
    pe_delay_line #(
        .DELAY_CYCLES(DELAY_CYCLES)
    ) u_delay_line (
        .clk      (clk),
        .rst      (rst),
        .in_valid (admit),
        .in_a     (gated_a),
        .in_b     (gated_b),
        .out_valid(out_valid),
        .out_a    (out_a),
        .out_b    (out_b)
    );

endmodule

`default_nettype wire

//--- rtl/pe_array_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module pe_array_ctrl #(
    parameter int NUM_PE = 4
) (
    input  wire                           clk,
    input  wire                           rst,

    // APB slave
    input  wire                           psel,
    input  wire                           penable,
    input  wire                           pwrite,
    input  wire pe_array_pkg::apb_addr_t  paddr,
    input  wire pe_array_pkg::apb_data_t  pwdata,
    output pe_array_pkg::apb_data_t       prdata,
    output logic                          pready,
    output logic                          pslverr,

    // Configuration broadcast
    output logic                          flush,
    output logic                          kl_valid,
    output logic                          kl_type,
    output pe_array_pkg::tag_t            kl_data,
    output logic [3:0]                    kl_pe,

    // Flags back from the PEs
    input  wire logic [NUM_PE-1:0]        pe_configured,
    input  wire logic [NUM_PE-1:0]        pe_match
);

    // Access phase qualifiers
    logic wr_en;
    logic rd_en;

    // Write decode
    logic wr_ctrl;
    logic wr_lock;
    logic wr_key;

    // Status word
    pe_array_pkg::apb_data_t status;

    //////////////////////////////////////////////////
    // APB handshake
    //////////////////////////////////////////////////

    // No wait states, no error responses
    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    assign wr_en = psel && penable && pwrite;
    assign rd_en = psel && penable && !pwrite;

    assign wr_ctrl = wr_en && (paddr == pe_array_pkg::REG_CTRL);
    assign wr_lock = wr_en && (paddr == pe_array_pkg::REG_LOCK);
    assign wr_key  = wr_en && (paddr == pe_array_pkg::REG_KEY);

    //////////////////////////////////////////////////
    // Broadcast pulses
    //////////////////////////////////////////////////

    // One cycle each, launched at the access edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flush    <= 1'b0;
            kl_valid <= 1'b0;
            kl_type  <= 1'b0;
        end else begin
            flush    <= wr_ctrl && pwdata[0];
            kl_valid <= wr_lock || wr_key;
            // Type held until the next lock or key
            if (wr_lock) begin
                kl_type <= 1'b0;
            end else if (wr_key) begin
                kl_type <= 1'b1;
            end
        end
    end

    // Broadcast payload, only looked at under kl_valid
    always_ff @(posedge clk) begin
        if (wr_lock || wr_key) begin
            kl_data <= pwdata[$bits(pe_array_pkg::tag_t)-1:0];
        end
        // Target index only for a lock
        if (wr_lock) begin
            kl_pe <= pwdata[pe_array_pkg::LOCK_PE_LSB +: 4];
        end
    end

    //////////////////////////////////////////////////
    // Read path
    //////////////////////////////////////////////////

    // Configured flags low, match flags high, unused PE slots zero
    always_comb begin
        status = '0;
        status[NUM_PE-1:0] = pe_configured;
        status[pe_array_pkg::STATUS_MATCH_LSB +: NUM_PE] = pe_match;
    end

    // Combinational in the access phase, zero otherwise
    always_comb begin
        prdata = '0;
        if (rd_en && (paddr == pe_array_pkg::REG_STATUS)) begin
            prdata = status;
        end
    end

endmodule

`default_nettype wire

//--- rtl/pe_array_pkg.sv
`default_nettype none

package pe_array_pkg;

    //////////////////////////////////////////////////
    // Tag layout
    //////////////////////////////////////////////////

    // Row and column halves of a lock or key
    localparam int ROW_W = 2;
    localparam int COL_W = 2;

    // Lock or key, row in the upper bits
    typedef logic [ROW_W+COL_W-1:0] tag_t;

    //////////////////////////////////////////////////
    // Data stream
    //////////////////////////////////////////////////

    // One operand of a broadcast pair
    typedef logic [15:0] operand_t;

    //////////////////////////////////////////////////
    // APB
    //////////////////////////////////////////////////

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Register map
    localparam apb_addr_t REG_CTRL   = 8'h00;
    localparam apb_addr_t REG_LOCK   = 8'h04;
    localparam apb_addr_t REG_KEY    = 8'h08;
    localparam apb_addr_t REG_STATUS = 8'h0C;

    // Field positions inside the write data
    localparam int LOCK_PE_LSB = 8;
    localparam int STATUS_MATCH_LSB = 16;

endpackage

`default_nettype wire

//--- rtl/pe_array_top.sv
`timescale 1ns/10ps
`default_nettype none

module pe_array_top #(
    parameter int NUM_PE       = 4,
    parameter int DELAY_CYCLES = 10
) (
    input  wire                           clk,
    input  wire                           rst,

    // APB slave
    input  wire                           psel,
    input  wire                           penable,
    input  wire                           pwrite,
    input  wire pe_array_pkg::apb_addr_t  paddr,
    input  wire pe_array_pkg::apb_data_t  pwdata,
    output pe_array_pkg::apb_data_t       prdata,
    output logic                          pready,
    output logic                          pslverr,

    // Operand stream, same beat to every PE
    input  wire                           in_valid,
    input  wire pe_array_pkg::operand_t   in_a,
    input  wire pe_array_pkg::operand_t   in_b,

    // Per-PE results, PE i in slice i
    output logic [NUM_PE-1:0]             out_valid,
    output logic [NUM_PE*16-1:0]          out_a,
    output logic [NUM_PE*16-1:0]          out_b
);

    // Configuration broadcast
    logic               flush;
    logic               kl_valid;
    logic               kl_type;
    pe_array_pkg::tag_t kl_data;
    logic [3:0]         kl_pe;

    // Flags back from the PEs
    logic [NUM_PE-1:0]  pe_configured;
    logic [NUM_PE-1:0]  pe_match;

    //////////////////////////////////////////////////
    // Controller
    //////////////////////////////////////////////////

    pe_array_ctrl #(
        .NUM_PE(NUM_PE)
    ) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .flush        (flush),
        .kl_valid     (kl_valid),
        .kl_type      (kl_type),
        .kl_data      (kl_data),
        .kl_pe        (kl_pe),
        .pe_configured(pe_configured),
        .pe_match     (pe_match)
    );

    //////////////////////////////////////////////////
    // PE array
    //////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_PE; i++) begin : g_pe
        dummy_pe #(
            .DELAY_CYCLES(DELAY_CYCLES),
            .PE_INDEX    (i)
        ) u_pe (
            .clk       (clk),
            .rst       (rst),
            .flush     (flush),
            .kl_valid  (kl_valid),
            .kl_type   (kl_type),
            .kl_data   (kl_data),
            .kl_pe     (kl_pe),
            .in_valid  (in_valid),
            .in_a      (in_a),
            .in_b      (in_b),
            .configured(pe_configured[i]),
            .match     (pe_match[i]),
            .out_valid (out_valid[i]),
            .out_a     (out_a[i*16 +: 16]),
            .out_b     (out_b[i*16 +: 16])
        );
    end

endmodule

`default_nettype wire

//--- rtl/pe_delay_line.sv
`timescale 1ns/10ps
`default_nettype none

module pe_delay_line #(
    parameter int DELAY_CYCLES = 10
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          in_valid,
    input  wire pe_array_pkg::operand_t  in_a,
    input  wire pe_array_pkg::operand_t  in_b,
    output logic                         out_valid,
    output pe_array_pkg::operand_t       out_a,
    output pe_array_pkg::operand_t       out_b
);

    // Shift stages, index 0 takes the input
    logic                   stage_valid [DELAY_CYCLES];
    pe_array_pkg::operand_t stage_a     [DELAY_CYCLES];
    pe_array_pkg::operand_t stage_b     [DELAY_CYCLES];

    //////////////////////////////////////////////////
    // Shift chain and output register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DELAY_CYCLES; i++) begin
                stage_valid[i] <= 1'b0;
                stage_a[i]     <= '0;
                stage_b[i]     <= '0;
            end
            out_valid <= 1'b0;
            out_a     <= '0;
            out_b     <= '0;
        end else begin
            // Head of the chain
            stage_valid[0] <= in_valid;
            stage_a[0]     <= in_a;
            stage_b[0]     <= in_b;
            // Move every beat one stage on
            for (int i = 1; i < DELAY_CYCLES; i++) begin
                stage_valid[i] <= stage_valid[i-1];
                stage_a[i]     <= stage_a[i-1];
                stage_b[i]     <= stage_b[i-1];
            end
            // Tail into the output register
            out_valid <= stage_valid[DELAY_CYCLES-1];
            out_a     <= stage_a[DELAY_CYCLES-1];
            out_b     <= stage_b[DELAY_CYCLES-1];
        end
    end

endmodule

`default_nettype wire

//--- rtl/pe_tag_match.sv
`timescale 1ns/10ps
`default_nettype none

module pe_tag_match #(
    parameter int PE_INDEX = 0
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      flush,
    input  wire                      kl_valid,
    input  wire                      kl_type,
    input  wire pe_array_pkg::tag_t  kl_data,
    input  wire logic [3:0]          kl_pe,
    output logic                     configured,
    output logic                     match
);

    // Own position on the broadcast bus
    localparam logic [3:0] PE_ID = 4'(PE_INDEX);

    // Stored lock
    pe_array_pkg::tag_t lock_tag;

    // Decoded broadcasts
    logic lock_hit;
    logic key_seen;

    // Lock only counts when addressed to this PE
    assign lock_hit = kl_valid && !kl_type && (kl_pe == PE_ID);
    // Every PE evaluates a key
    assign key_seen = kl_valid && kl_type;

    //////////////////////////////////////////////////
    // Lock, configured and match registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lock_tag   <= '0;
            configured <= 1'b0;
            match      <= 1'b0;
        end else if (flush) begin
            // Drop the whole configuration
            lock_tag   <= '0;
            configured <= 1'b0;
            match      <= 1'b0;
        end else if (lock_hit) begin
            // New lock, old selection no longer valid
            lock_tag   <= kl_data;
            configured <= 1'b1;
            match      <= 1'b0;
        end else if (key_seen) begin
            // Unconfigured PE never matches
            match <= configured && (lock_tag == kl_data);
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the PE array testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

# Testbench and RTL into one binary
verilator --binary --timing --assert \
    --top-module pe_array_tb \
    --Mdir "$OBJ" -o pe_array_sim \
    -f sim.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Run and keep the transcript
"$OBJ/pe_array_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -qF "*** TEST FAILED ***" "$LOG"; then
    echo "Simulation reported failure, see $LOG"
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
echo "Simulation finished without failure"
exit 0

//--- sim.f
rtl/pe_array_pkg.sv
rtl/pe_tag_match.sv
rtl/pe_delay_line.sv
rtl/dummy_pe.sv
rtl/pe_array_ctrl.sv
rtl/pe_array_top.sv
tests/pe_array_tb.sv

//--- tests/pe_array_tb.sv
`timescale 1ns/10ps
`default_nettype none

module pe_array_tb;

    localparam int NUM_PE       = 4;
    localparam int DELAY_CYCLES = 10;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int DRAIN        = DELAY_CYCLES + 2;
    localparam int RANDOM_OPS   = 300;
    // Watchdog budget from the beats and APB transfers of all tests
    localparam int STREAM_BEATS = 195;
    localparam int APB_XFERS    = 30;
    localparam int RUN_CYCLES   = RESET_CYCLES + STREAM_BEATS + 6 * DRAIN
                                + 2 * APB_XFERS + 4 * RANDOM_OPS;
    localparam int WATCHDOG_NS  = 2 * RUN_CYCLES * CLK_PERIOD;

    // DUT ports
    logic                    clk = 1'b0;
    logic                    rst;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    pe_array_pkg::apb_addr_t paddr;
    pe_array_pkg::apb_data_t pwdata;
    pe_array_pkg::apb_data_t prdata;
    logic                    pready;
    logic                    pslverr;
    logic                    in_valid;
    pe_array_pkg::operand_t  in_a;
    pe_array_pkg::operand_t  in_b;
    logic [NUM_PE-1:0]       out_valid;
    logic [NUM_PE*16-1:0]    out_a;
    logic [NUM_PE*16-1:0]    out_b;

    // Bench state
    logic [31:0]             lfsr_state = 32'hb686b11a;
    logic                    stream_on = 1'b0;
    logic                    check_en = 1'b0;
    string                   test_name;
    pe_array_pkg::tag_t      cur_lock [NUM_PE];

    // Model of the array
    int                      cyc;
    pe_array_pkg::tag_t      m_lock [NUM_PE];
    logic [NUM_PE-1:0]       m_cfg;
    logic [NUM_PE-1:0]       m_match;
    logic                    p_flush;
    logic                    p_kl_valid;
    logic                    p_kl_type;
    pe_array_pkg::tag_t      p_kl_data;
    logic [3:0]              p_kl_pe;
    logic [NUM_PE-1:0]       adm_v;
    logic [NUM_PE*16-1:0]    adm_a;
    logic [NUM_PE*16-1:0]    adm_b;
    // Expected outputs with one entry per cycle
    int                      q_due [$];
    logic [NUM_PE-1:0]       q_valid [$];
    logic [NUM_PE*16-1:0]    q_a [$];
    logic [NUM_PE*16-1:0]    q_b [$];
    logic [NUM_PE-1:0]       chk_v;
    logic [NUM_PE*16-1:0]    chk_a;
    logic [NUM_PE*16-1:0]    chk_b;

    pe_array_top #(
        .NUM_PE      (NUM_PE),
        .DELAY_CYCLES(DELAY_CYCLES)
    ) uut (
        .clk      (clk),
        .rst      (rst),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .in_valid (in_valid),
        .in_a     (in_a),
        .in_b     (in_b),
        .out_valid(out_valid),
        .out_a    (out_a),
        .out_b    (out_b)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // Random numbers and reporting
    //////////////////////////////////////////////////

    // Galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("FAIL %s %s: expected %0h actual %0h", test_name, what, exp, act);
        $display("*** TEST FAILED ***");
        $fatal(1, "Mismatch on %s", what);
    endtask

    function automatic logic lock_taken(input pe_array_pkg::tag_t t, input int count);
        for (int i = 0; i < count; i++) begin
            if (cur_lock[i] == t) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////

    // Advance one clock and drive a fresh beat that is valid about 3 in 4
    task automatic next_cycle();
        @(posedge clk);
        #2;
        in_valid = stream_on && (rand_bits(2) != 0);
        in_a     = pe_array_pkg::operand_t'(rand_bits(16));
        in_b     = pe_array_pkg::operand_t'(rand_bits(16));
    endtask

    task automatic run_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    // Setup then access phase with no wait states
    task automatic write_reg(input pe_array_pkg::apb_addr_t addr,
                             input pe_array_pkg::apb_data_t data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        next_cycle();
        penable = 1'b1;
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_lock(input int pe, input pe_array_pkg::tag_t t);
        write_reg(pe_array_pkg::REG_LOCK, {20'd0, 4'(pe), 4'd0, t});
    endtask

    task automatic write_key(input pe_array_pkg::tag_t t);
        write_reg(pe_array_pkg::REG_KEY, {28'd0, t});
    endtask

    // Status read compared mid access phase
    task automatic read_status();
        pe_array_pkg::apb_data_t exp;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = pe_array_pkg::REG_STATUS;
        next_cycle();
        penable = 1'b1;
        @(negedge clk);
        exp = '0;
        exp[NUM_PE-1:0]  = m_cfg;
        exp[16 +: NUM_PE] = m_match;
        assert (prdata == exp) else report_mismatch("status", 64'(exp), 64'(prdata));
        assert (pready) else report_mismatch("pready", 64'(1), 64'(pready));
        assert (!pslverr) else report_mismatch("pslverr", 64'(0), 64'(pslverr));
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Model and output checker
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            cyc        = 0;
            m_cfg      = '0;
            m_match    = '0;
            p_flush    = 1'b0;
            p_kl_valid = 1'b0;
            for (int i = 0; i < NUM_PE; i++) begin
                m_lock[i] = '0;
            end
            q_due.delete();
            q_valid.delete();
            q_a.delete();
            q_b.delete();
        end else begin
            cyc = cyc + 1;
            // Admission uses the flags from before this edge
            for (int i = 0; i < NUM_PE; i++) begin
                adm_v[i] = in_valid && m_match[i];
                adm_a[i*16 +: 16] = adm_v[i] ? in_a : 16'h0;
                adm_b[i*16 +: 16] = adm_v[i] ? in_b : 16'h0;
            end
            q_due.push_back(cyc + DELAY_CYCLES);
            q_valid.push_back(adm_v);
            q_a.push_back(adm_a);
            q_b.push_back(adm_b);
            // Broadcast launched one edge ago lands now
            for (int i = 0; i < NUM_PE; i++) begin
                if (p_flush) begin
                    m_lock[i]  = '0;
                    m_cfg[i]   = 1'b0;
                    m_match[i] = 1'b0;
                end else if (p_kl_valid && !p_kl_type && p_kl_pe == 4'(i)) begin
                    m_lock[i]  = p_kl_data;
                    m_cfg[i]   = 1'b1;
                    m_match[i] = 1'b0;
                end else if (p_kl_valid && p_kl_type) begin
                    m_match[i] = m_cfg[i] && (m_lock[i] == p_kl_data);
                end
            end
            // Write seen in its access phase
            p_flush    = psel && penable && pwrite && paddr == pe_array_pkg::REG_CTRL
                         && pwdata[0];
            p_kl_valid = psel && penable && pwrite && (paddr == pe_array_pkg::REG_LOCK
                         || paddr == pe_array_pkg::REG_KEY);
            p_kl_type  = (paddr == pe_array_pkg::REG_KEY);
            p_kl_data  = pwdata[3:0];
            p_kl_pe    = pwdata[11:8];
        end
    end

    // Outputs settle after the edge and are compared at the falling edge
    always @(negedge clk) begin
        if (check_en) begin
            chk_v = '0;
            chk_a = '0;
            chk_b = '0;
            if (q_due.size() != 0 && q_due[0] == cyc) begin
                chk_v = q_valid.pop_front();
                chk_a = q_a.pop_front();
                chk_b = q_b.pop_front();
                void'(q_due.pop_front());
            end
            assert (out_valid == chk_v) else report_mismatch("out_valid", 64'(chk_v),
                                                             64'(out_valid));
            assert (out_a == chk_a) else report_mismatch("out_a", 64'(chk_a), 64'(out_a));
            assert (out_b == chk_b) else report_mismatch("out_b", 64'(chk_b), 64'(out_b));
        end
    end

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    initial begin
        pe_array_pkg::tag_t t;
        int k;
        int op;
        rst      = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        in_valid = 1'b0;
        in_a     = '0;
        in_b     = '0;
        test_name = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst      = 1'b0;
        check_en = 1'b1;

        // Nothing configured so nothing comes out
        test_name = "idle_after_reset";
        read_status();
        stream_on = 1'b1;
        run_cycles(30);
        stream_on = 1'b0;
        run_cycles(DRAIN);

        // Unique locks then a hitting key and a missing key
        test_name = "lock_and_key";
        for (int i = 0; i < NUM_PE; i++) begin
            do begin
                t = pe_array_pkg::tag_t'(rand_bits(4));
            end while (lock_taken(t, i));
            cur_lock[i] = t;
            write_lock(i, t);
            read_status();
        end
        k = int'(rand_bits(2));
        write_key(cur_lock[k]);
        read_status();
        do begin
            t = pe_array_pkg::tag_t'(rand_bits(4));
        end while (lock_taken(t, NUM_PE));
        write_key(t);
        read_status();

        // One PE selected for a gappy stream
        test_name = "single_pe_stream";
        k = int'(rand_bits(2));
        write_key(cur_lock[k]);
        read_status();
        stream_on = 1'b1;
        run_cycles(60);
        stream_on = 1'b0;
        run_cycles(DRAIN);

        // PE 1 and 2 share a lock and the key moves to PE 0 mid stream
        test_name = "shared_lock";
        do begin
            t = pe_array_pkg::tag_t'(rand_bits(4));
        end while (t == cur_lock[0] || t == cur_lock[3]);
        cur_lock[1] = t;
        cur_lock[2] = t;
        write_lock(1, t);
        write_lock(2, t);
        write_key(t);
        read_status();
        stream_on = 1'b1;
        run_cycles(20);
        write_key(cur_lock[0]);
        run_cycles(20);
        stream_on = 1'b0;
        run_cycles(DRAIN);

        // Flush in flight then reconfigure
        test_name = "flush_mid_stream";
        write_key(t);
        stream_on = 1'b1;
        run_cycles(15);
        write_reg(pe_array_pkg::REG_CTRL, 32'h1);
        read_status();
        run_cycles(20);
        stream_on = 1'b0;
        run_cycles(DRAIN);
        t = pe_array_pkg::tag_t'(rand_bits(4));
        write_lock(3, t);
        write_key(t);
        read_status();
        stream_on = 1'b1;
        run_cycles(30);
        stream_on = 1'b0;
        run_cycles(DRAIN);

        // Random operations over a running stream
        test_name = "random_mix";
        stream_on = 1'b1;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            op = int'(rand_bits(3));
            case (op)
                0, 1: write_lock(int'(rand_bits(2)), pe_array_pkg::tag_t'(rand_bits(4)));
                2, 3: begin
                    k = int'(rand_bits(2));
                    // Half the keys aimed at a current lock
                    if (rand_bits(1) != 0) begin
                        write_key(m_lock[k]);
                    end else begin
                        write_key(pe_array_pkg::tag_t'(rand_bits(4)));
                    end
                end
                4: begin
                    if (rand_bits(2) == 0) begin
                        write_reg(pe_array_pkg::REG_CTRL, 32'h1);
                    end else begin
                        read_status();
                    end
                end
                5: read_status();
                default: run_cycles(int'(rand_bits(2)) + 1);
            endcase
        end
        stream_on = 1'b0;
        run_cycles(DRAIN);

        $display("*** TEST PASSED ***");
        $finish;
    end

    // Hard stop well past the expected run length
    initial begin
        #(WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $fatal(1, "Watchdog timeout, the run did not finish within %0d ns", WATCHDOG_NS);
    end

endmodule

`default_nettype wire
